// ==== src.f ====
+incdir+.
rename_pkg.sv
rename_intake.sv
free_list.sv
map_table.sv
rename_outbuf.sv
rename_top.sv
rename_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rename_tb -o rename_sim

run: compile
	@out="$$(./obj_dir/rename_sim)"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== rename_tb.sv ====
`include "rename_consts.svh"

module rename_tb
    import rename_pkg::*;
();

    // one stimulus step, a bundle plus optional completions and retirements
    typedef struct packed {
        logic                  has_bundle;
        decoded_bundle_t       bundle;
        wakeup_t [`WIDTH-1:0]  wakeups;
        release_t [`WIDTH-1:0] releases;
        logic                  hold;   // downstream keeps its credits
    } row_t;

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    decoded_bundle_t       in_bundle;
    logic                  in_credit;
    wakeup_t [`WIDTH-1:0]  wakeups;
    release_t [`WIDTH-1:0] releases;
    logic                  out_valid;
    renamed_bundle_t       out_bundle;
    logic                  out_credit;

    row_t            rows [$];
    map_entry_t      model_map [`ARCH_REGS];
    phys_idx_t       free_q [$];     // reference free list, pops in order
    decoded_bundle_t sent_q [$];     // driven, not yet seen at the output
    int              up_credits;
    int              down_credits;   // credits the DUT holds toward downstream
    int              owed;           // bundles taken and not yet credited back
    int              received;
    int              cycle_count = 0;
    int              timeout_limit = 0;
    logic [7:0]      lfsr;

    rename_top dut_i (
        .clock, .reset,
        .in_valid, .in_bundle, .in_credit,
        .wakeups, .releases,
        .out_valid, .out_bundle, .out_credit
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            report_error($sformatf("timeout after %0d cycles, %0d bundles never came out",
                                   cycle_count, sent_q.size()));
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    function automatic decoded_slot_t ins(input int dest, input int src1, input int src2);
        decoded_slot_t s;
        s.valid = 1'b1;
        s.src1  = arch_idx_t'(src1);
        s.src2  = arch_idx_t'(src2);
        s.dest  = arch_idx_t'(dest);
        return s;
    endfunction

    function automatic wakeup_t wake(input int arch, input int phys);
        wakeup_t w;
        w.valid = 1'b1;
        w.arch  = arch_idx_t'(arch);
        w.phys  = phys_idx_t'(phys);
        return w;
    endfunction

    function automatic release_t free_reg(input int phys);
        release_t r;
        r.valid = 1'b1;
        r.phys  = phys_idx_t'(phys);
        return r;
    endfunction

    function automatic string slot_text(input renamed_slot_t s);
        return $sformatf("src1 p%0d/%0b src2 p%0d/%0b new p%0d old p%0d",
                         s.src1.phys, s.src1.ready, s.src2.phys, s.src2.ready,
                         s.new_dest, s.old_dest);
    endfunction

    task automatic add_row(input decoded_slot_t s0, input decoded_slot_t s1,
                           input wakeup_t w0, input wakeup_t w1,
                           input release_t r0, input release_t r1, input logic hold);
        row_t r;
        r.has_bundle  = s0.valid || s1.valid;
        r.bundle[0]   = s0;
        r.bundle[1]   = s1;
        r.wakeups[0]  = w0;
        r.wakeups[1]  = w1;
        r.releases[0] = r0;
        r.releases[1] = r1;
        r.hold        = hold;
        rows.push_back(r);
    endtask

    task automatic add_bundle(input decoded_slot_t s0, input decoded_slot_t s1,
                              input logic hold);
        add_row(s0, s1, '0, '0, '0, '0, hold);
    endtask

    task automatic build_table();
        add_bundle(ins(3, 1, 2), '0, 1'b0);              // fresh after reset
        add_bundle(ins(4, 1, 3), ins(5, 4, 4), 1'b0);    // slot 1 reads slot 0's dest
        add_bundle(ins(0, 4, 5), ins(6, 0, 0), 1'b0);    // dest 0 takes nothing
        add_row(ins(7, 3, 1), '0, wake(3, 32), '0, '0, '0, 1'b0);
        add_bundle(ins(4, 0, 0), '0, 1'b0);              // r4 moves to a new register
        // r4 no longer maps to p33, so this wakeup is stale
        add_row(ins(8, 4, 5), '0, wake(4, 33), '0, '0, '0, 1'b0);
        add_row(ins(9, 4, 5), '0, wake(4, 37), wake(5, 34), '0, '0, 1'b0);
        for (int i = 0; i < 12; i++) begin
            add_bundle(ins(10 + i, i + 1, 9), ins(31 - i, 10 + i, 3), 1'b0);
        end
        // free list is empty now, this one waits for retirement
        add_bundle(ins(1, 2, 3), ins(2, 1, 0), 1'b0);
        repeat (3) add_bundle('0, '0, 1'b0);
        add_row('0, '0, '0, '0, free_reg(3), free_reg(4), 1'b0);
        add_row(ins(11, 1, 2), '0, '0, '0, free_reg(5), free_reg(6), 1'b0);
        add_bundle(ins(12, 11, 1), '0, 1'b1);
        for (int i = 0; i < 5; i++) begin
            add_bundle(ins(0, i, i + 1), ins(0, 12, i), 1'b1);
        end
        repeat (4) add_bundle('0, '0, 1'b1);             // out_valid must drop
        add_bundle(ins(0, 12, 1), '0, 1'b0);
        add_row(ins(0, 12, 11), '0, wake(12, 6), '0, '0, '0, 1'b0);
    endtask

    // rename rules applied slot by slot against the reference table
    task automatic rename_model(input decoded_bundle_t b, output renamed_bundle_t r);
        for (int i = 0; i < `WIDTH; i++) begin
            r[i].valid    = b[i].valid;
            r[i].src1     = model_map[b[i].src1];
            r[i].src2     = model_map[b[i].src2];
            r[i].old_dest = model_map[b[i].dest].phys;
            r[i].new_dest = r[i].old_dest;
            if (b[i].valid && b[i].dest != '0) begin
                assert (free_q.size() != 0)
                    else report_error("reference free list ran empty, no register to expect");
                r[i].new_dest              = free_q.pop_front();
                model_map[b[i].dest].phys  = r[i].new_dest;
                model_map[b[i].dest].ready = 1'b0;
            end
        end
    endtask

    task automatic check_bundle();
        decoded_bundle_t b;
        renamed_bundle_t exp;
        assert (sent_q.size() != 0)
            else report_error("out_valid came with no bundle left to expect");
        assert (down_credits > 0)
            else report_error("out_valid came while the DUT held no downstream credit");
        b = sent_q.pop_front();
        rename_model(b, exp);
        for (int i = 0; i < `WIDTH; i++) begin
            assert (out_bundle[i].valid == exp[i].valid)
                else report_error($sformatf("Fail at %0t: bundle %0d slot %0d valid %0b, expected %0b",
                                            $time, received, i, out_bundle[i].valid, exp[i].valid));
            if (exp[i].valid) begin
                assert (out_bundle[i] == exp[i])
                    else report_error($sformatf("Fail at %0t: bundle %0d slot %0d got %s, expected %s",
                                                $time, received, i, slot_text(out_bundle[i]),
                                                slot_text(exp[i])));
            end
        end
        received++;
        down_credits--;
        owed++;
    endtask

    // sample at the falling edge, then drive the next inputs
    task automatic next_cycle(input row_t r);
        @(negedge clock);
        if (in_credit) up_credits++;
        if (out_valid) check_bundle();
        in_valid  = r.has_bundle;
        in_bundle = r.bundle;
        wakeups   = r.wakeups;
        releases  = r.releases;
        lfsr       = lfsr_next(lfsr);
        out_credit = (owed > 0) && !r.hold && lfsr[0];
        if (out_credit) begin
            owed--;
            down_credits++;
        end
        if (r.has_bundle) begin
            up_credits--;
            sent_q.push_back(r.bundle);
        end
        for (int i = 0; i < `WIDTH; i++) begin
            if (r.releases[i].valid) free_q.push_back(r.releases[i].phys);
        end
        for (int w = 0; w < `WIDTH; w++) begin
            if (r.wakeups[w].valid && model_map[r.wakeups[w].arch].phys == r.wakeups[w].phys) begin
                model_map[r.wakeups[w].arch].ready = 1'b1;
            end
        end
    endtask

    task automatic idle(input logic hold);
        row_t r;
        r      = '0;
        r.hold = hold;
        next_cycle(r);
    endtask

    task automatic drain();
        while (sent_q.size() != 0) idle(1'b0);
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_bundle    = '0;
        wakeups      = '0;
        releases     = '0;
        out_credit   = 1'b0;
        lfsr         = 8'd78;
        up_credits   = `INTAKE_DEPTH;
        down_credits = `OUT_CREDITS;
        owed         = 0;
        received     = 0;
        for (int a = 0; a < `ARCH_REGS; a++) begin
            model_map[a].phys  = phys_idx_t'(a);
            model_map[a].ready = 1'b1;
        end
        for (int p = `ARCH_REGS; p < `PHYS_REGS; p++) begin
            free_q.push_back(phys_idx_t'(p));
        end
        build_table();
        timeout_limit = 20 * rows.size() + 50;

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        foreach (rows[n]) begin
            // a wakeup is judged against the mapping with nothing in flight
            if (rows[n].wakeups[0].valid || rows[n].wakeups[1].valid) drain();
            if (rows[n].has_bundle) begin
                while (up_credits == 0) idle(1'b0);
            end
            next_cycle(rows[n]);
        end
        drain();
        repeat (4) idle(1'b0);
        assert (up_credits == `INTAKE_DEPTH)
            else report_error("intake did not hand back all upstream credits");
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== rename_top.sv ====
`include "rename_consts.svh"

module rename_top
    import rename_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    input  decoded_bundle_t      in_bundle,
    output logic                 in_credit,
    input  wakeup_t [`WIDTH-1:0]  wakeups,
    input  release_t [`WIDTH-1:0] releases,
    output logic                 out_valid,
    output renamed_bundle_t      out_bundle,
    input  logic                 out_credit
);

    decoded_bundle_t        head_bundle;
    logic [`WIDTH-1:0]      alloc_mask;
    logic                   fire;
    logic                   can_grant;
    logic                   out_ready;
    phys_idx_t [`WIDTH-1:0] grant_regs;
    renamed_bundle_t        renamed;

    rename_intake intake_i (
        .clock, .reset,
        .in_valid, .in_bundle, .in_credit,
        .can_grant, .out_ready,
        .head_bundle, .alloc_mask, .fire
    );

    free_list free_list_i (
        .clock, .reset,
        .alloc_mask, .fire, .releases,
        .grant_regs, .can_grant
    );

    map_table map_table_i (
        .clock, .reset,
        .head_bundle, .alloc_mask, .grant_regs, .fire, .wakeups,
        .renamed
    );

    rename_outbuf outbuf_i (
        .clock, .reset,
        .fire, .renamed, .out_credit,
        .out_ready, .out_valid, .out_bundle
    );

endmodule

// ==== rename_outbuf.sv ====
`include "rename_consts.svh"

module rename_outbuf
    import rename_pkg::*;
(
    input  logic            clock,
    input  logic            reset,
    input  logic            fire,
    input  renamed_bundle_t renamed,
    input  logic            out_credit,
    output logic            out_ready,
    output logic            out_valid,
    output renamed_bundle_t out_bundle
);

    // one spare count so an extra credit from downstream shows up
    localparam int CRD_W = $clog2(`OUT_CREDITS + 2);

    logic             held;   // register holds a bundle not yet sent
    logic [CRD_W-1:0] credits;
    logic             send;

    assign send      = held && (credits != '0);
    assign out_valid = send;
    assign out_ready = !held || send;   // free now or freed this cycle

    always_ff @(posedge clock) begin
        if (fire) begin
            out_bundle <= renamed;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            held    <= 1'b0;
            credits <= CRD_W'(`OUT_CREDITS);
        end else begin
            if (fire) begin
                held <= 1'b1;
            end else if (send) begin
                held <= 1'b0;
            end
            credits <= credits + CRD_W'(out_credit) - CRD_W'(send);   // one per bundle
        end
    end

    // downstream never returns more credits than bundles it was sent
    a_credit_cap: assert property (
        @(posedge clock) disable iff (reset)
        credits <= CRD_W'(`OUT_CREDITS)
    ) else $error("downstream credit count above its limit");

endmodule

// ==== map_table.sv ====
`include "rename_consts.svh"

module map_table
    import rename_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  decoded_bundle_t        head_bundle,
    input  logic [`WIDTH-1:0]      alloc_mask,
    input  phys_idx_t [`WIDTH-1:0] grant_regs,
    input  logic                   fire,
    input  wakeup_t [`WIDTH-1:0]   wakeups,
    output renamed_bundle_t        renamed
);

    map_entry_t table_q       [`ARCH_REGS];
    map_entry_t table_woken   [`ARCH_REGS];   // after this cycle's completions
    map_entry_t table_renamed [`ARCH_REGS];   // after this cycle's bundle as well

    // ready is set only if the broadcast still matches the current mapping
    always_comb begin
        table_woken = table_q;
        for (int w = 0; w < `WIDTH; w++) begin
            if (wakeups[w].valid &&
                table_woken[wakeups[w].arch].phys == wakeups[w].phys) begin
                table_woken[wakeups[w].arch].ready = 1'b1;
            end
        end
    end

    // read then write per slot, so slot 1 sees slot 0's new mapping
    always_comb begin
        phys_idx_t old_dest;

        table_renamed = table_woken;
        for (int i = 0; i < `WIDTH; i++) begin
            old_dest = table_renamed[head_bundle[i].dest].phys;

            renamed[i].valid    = head_bundle[i].valid;
            renamed[i].src1     = table_renamed[head_bundle[i].src1];
            renamed[i].src2     = table_renamed[head_bundle[i].src2];
            renamed[i].old_dest = old_dest;
            renamed[i].new_dest = old_dest;   // unchanged when no register is taken

            if (alloc_mask[i]) begin
                renamed[i].new_dest = grant_regs[i];
                table_renamed[head_bundle[i].dest].phys  = grant_regs[i];
                table_renamed[head_bundle[i].dest].ready = 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                table_q[a].phys  <= phys_idx_t'(a);   // identity mapping
                table_q[a].ready <= 1'b1;
            end
        end else begin
            // entry 0 keeps its reset value, physical 0 and ready
            for (int a = 1; a < `ARCH_REGS; a++) begin
                table_q[a] <= fire ? table_renamed[a] : table_woken[a];
            end
        end
    end

    // the free list never holds register 0, so no slot may be given it
    for (genvar s = 0; s < `WIDTH; s++) begin : g_grant_chk
        a_no_grant_zero: assert property (
            @(posedge clock) disable iff (reset)
            (fire && alloc_mask[s]) |-> (grant_regs[s] != '0)
        ) else $error("slot %0d renamed to physical register 0", s);
    end

endmodule

// ==== free_list.sv ====
`include "rename_consts.svh"

module free_list
    import rename_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [`WIDTH-1:0]    alloc_mask,
    input  logic                 fire,
    input  release_t [`WIDTH-1:0] releases,
    output phys_idx_t [`WIDTH-1:0] grant_regs,
    output logic                 can_grant
);

    localparam int FL_DEPTH = `FREE_REGS;
    localparam int PTR_W    = $clog2(FL_DEPTH);   // depth is a power of two, pointers wrap
    localparam int CNT_W    = $clog2(FL_DEPTH + 1);
    localparam int NUM_W    = $clog2(`WIDTH + 1);

    phys_idx_t        fl_mem [FL_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic [NUM_W-1:0] n_alloc;
    logic [NUM_W-1:0] n_pop;
    logic [NUM_W-1:0] n_release;
    logic [PTR_W-1:0] wr_ptr [`WIDTH];
    logic             rel_zero;

    // slots that need a register take them from the head in slot order
    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < `WIDTH; i++) begin
            grant_regs[i] = fl_mem[head_ptr + PTR_W'(n_alloc)];
            n_alloc       = n_alloc + NUM_W'(alloc_mask[i]);
        end
    end

    assign can_grant = (count >= CNT_W'(n_alloc));
    assign n_pop     = fire ? n_alloc : '0;

    // valid releases are packed at the tail in port order
    always_comb begin
        n_release = '0;
        rel_zero  = 1'b0;
        for (int i = 0; i < `WIDTH; i++) begin
            wr_ptr[i] = tail_ptr + PTR_W'(n_release);
            if (releases[i].valid) begin
                n_release = n_release + 1'b1;
                rel_zero  = rel_zero || (releases[i].phys == '0);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fl_mem[i] <= phys_idx_t'(`ARCH_REGS + i);   // 32..63 start out free
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= CNT_W'(FL_DEPTH);
        end else begin
            for (int i = 0; i < `WIDTH; i++) begin
                if (releases[i].valid) begin
                    fl_mem[wr_ptr[i]] <= releases[i].phys;
                end
            end
            head_ptr <= head_ptr + PTR_W'(n_pop);
            tail_ptr <= tail_ptr + PTR_W'(n_release);
            count    <= count - CNT_W'(n_pop) + CNT_W'(n_release);
        end
    end

    // retirement can only return what rename handed out
    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset)
        count <= CNT_W'(FL_DEPTH)
    ) else $error("free list overflow, more releases than allocations");

    // register 0 is never allocated, so it can never come back
    a_no_release_zero: assert property (
        @(posedge clock) disable iff (reset)
        !rel_zero
    ) else $error("physical register 0 released to the free list");

endmodule

// ==== rename_intake.sv ====
`include "rename_consts.svh"

module rename_intake
    import rename_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  logic              in_valid,
    input  decoded_bundle_t   in_bundle,
    output logic              in_credit,
    input  logic              can_grant,
    input  logic              out_ready,
    output decoded_bundle_t   head_bundle,
    output logic [`WIDTH-1:0] alloc_mask,
    output logic              fire
);

    localparam int PTR_W = $clog2(`INTAKE_DEPTH);
    localparam int CNT_W = $clog2(`INTAKE_DEPTH + 1);

    decoded_bundle_t  queue [`INTAKE_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic             head_valid;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`INTAKE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_valid  = (count != '0);
    assign head_bundle = queue[head_ptr];
    assign fire        = head_valid && can_grant && out_ready;   // bundle leaves this cycle

    always_comb begin
        for (int i = 0; i < `WIDTH; i++) begin
            // dest 0 is hardwired, it never takes a register
            alloc_mask[i] = head_valid && head_bundle[i].valid && (head_bundle[i].dest != '0);
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            queue[tail_ptr] <= in_bundle;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr  <= '0;
            tail_ptr  <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) tail_ptr <= next_ptr(tail_ptr);
            if (fire) head_ptr <= next_ptr(head_ptr);
            case ({in_valid, fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            in_credit <= fire;   // one credit back per pop
        end
    end

    // the sender holds at most INTAKE_DEPTH credits, so a push never meets a full queue
    a_no_push_when_full: assert property (
        @(posedge clock) disable iff (reset)
        in_valid |-> (count < CNT_W'(`INTAKE_DEPTH))
    ) else $error("intake push into a full queue, upstream credit violation");

endmodule

// ==== rename_pkg.sv ====
`include "rename_consts.svh"

package rename_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_idx_t;   // 5 bits
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_idx_t;   // 6 bits

    // one map table entry
    typedef struct packed {
        phys_idx_t phys;
        logic      ready;
    } map_entry_t;

    typedef struct packed {
        logic      valid;
        arch_idx_t src1;
        arch_idx_t src2;
        arch_idx_t dest;    // 0 means no destination
    } decoded_slot_t;

    typedef decoded_slot_t [`WIDTH-1:0] decoded_bundle_t;

    typedef struct packed {
        logic       valid;
        map_entry_t src1;
        map_entry_t src2;
        phys_idx_t  new_dest;
        phys_idx_t  old_dest;   // freed when this instruction retires
    } renamed_slot_t;

    typedef renamed_slot_t [`WIDTH-1:0] renamed_bundle_t;

    // completion broadcast
    typedef struct packed {
        logic      valid;
        arch_idx_t arch;
        phys_idx_t phys;
    } wakeup_t;

    // retirement returns an old dest to the free list
    typedef struct packed {
        logic      valid;
        phys_idx_t phys;
    } release_t;

endpackage

// ==== rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes
`define ARCH_REGS       32
`define PHYS_REGS       64

// slots per decoded bundle
`define WIDTH           2

// intake queue entries, equal to the upstream credits after reset
`define INTAKE_DEPTH    4

// credits held toward dispatch after reset
`define OUT_CREDITS     2

// free list holds every physical register not mapped at reset
`define FREE_REGS       (`PHYS_REGS - `ARCH_REGS)

`endif
